/* Bender.yml */
package:
  name: ext_mem

sources:
  - logic/mem_bus_pkg.sv
  - logic/cache_pkg.sv
  - logic/l1_cache.sv
  - logic/bus_merge.sv
  - logic/l2_cache.sv
  - logic/ext_mem.sv
  - target: test
    files:
      - tb/mem_model.sv
      - tb/ext_mem_tb.sv

/* ext_mem.f */
logic/mem_bus_pkg.sv
logic/cache_pkg.sv
logic/l1_cache.sv
logic/bus_merge.sv
logic/l2_cache.sv
logic/ext_mem.sv
tb/mem_model.sv
tb/ext_mem_tb.sv

/* logic/bus_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_merge #(
   parameter int ADDR_W = 16
) (
   input  logic                                clk_i,
   input  logic                                rst_i,
   // Masters, indexed by mem_bus_pkg::MASTER_I and MASTER_D
   input  logic [1:0]                          m_req_i,
   input  logic [1:0][ADDR_W-1:0]              m_addr_i,
   input  logic [1:0][mem_bus_pkg::DATA_W-1:0] m_wdata_i,
   input  logic [1:0][mem_bus_pkg::STRB_W-1:0] m_wstrb_i,
   output logic [mem_bus_pkg::DATA_W-1:0]      m_rdata_o,   // Shared by both masters
   output logic [1:0]                          m_ack_o,
   // Slave
   output logic                                s_req_o,
   output logic [ADDR_W-1:0]                   s_addr_o,
   output logic [mem_bus_pkg::DATA_W-1:0]      s_wdata_o,
   output logic [mem_bus_pkg::STRB_W-1:0]      s_wstrb_o,
   input  logic [mem_bus_pkg::DATA_W-1:0]      s_rdata_i,
   input  logic                                s_ack_i
);

   cache_pkg::merge_state_e state_q;
   logic                    grant_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= cache_pkg::MG_IDLE;
         grant_q <= mem_bus_pkg::MASTER_D;
      end else begin
         case (state_q)
            cache_pkg::MG_IDLE: begin
               // Fixed priority, instruction side first
               if (m_req_i[mem_bus_pkg::MASTER_I]) begin
                  grant_q <= mem_bus_pkg::MASTER_I;
                  state_q <= cache_pkg::MG_BUSY;
               end else if (m_req_i[mem_bus_pkg::MASTER_D]) begin
                  grant_q <= mem_bus_pkg::MASTER_D;
                  state_q <= cache_pkg::MG_BUSY;
               end
            end
            default: begin
               if (s_ack_i) begin
                  state_q <= cache_pkg::MG_IDLE;   // Re-arbitrate after every transfer
               end
            end
         endcase
      end
   end

   assign s_req_o   = (state_q == cache_pkg::MG_BUSY);
   assign s_addr_o  = m_addr_i[grant_q];
   assign s_wdata_o = m_wdata_i[grant_q];
   assign s_wstrb_o = m_wstrb_i[grant_q];
   assign m_rdata_o = s_rdata_i;

   // Ack steered to the granted master only
   always_comb begin
      m_ack_o          = '0;
      m_ack_o[grant_q] = s_req_o && s_ack_i;
   end

endmodule

`default_nettype wire

/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

   typedef enum logic [1:0] {
      L1_IDLE,
      L1_LOOKUP,
      L1_BACKEND,   // Miss fill or write-through
      L1_CTRL
   } l1_state_e;

   typedef enum logic [2:0] {
      L2_IDLE,
      L2_LOOKUP,
      L2_DRAIN_WAIT,   // Read miss waits for older writes
      L2_FETCH,
      L2_WRITE_PUSH
   } l2_state_e;

   typedef enum logic {
      MG_IDLE,
      MG_BUSY
   } merge_state_e;

endpackage

`default_nettype wire

/* logic/ext_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module ext_mem #(
   parameter int ADDR_W        = 16,
   parameter int L1_LINES_W    = 4,
   parameter int L2_LINES_W    = 6,
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                           clk_i,
   input  logic                           rst_i,
   // Instruction bus, read only
   input  logic                           i_req_i,
   input  logic [ADDR_W-1:0]              i_addr_i,
   output logic [mem_bus_pkg::DATA_W-1:0] i_rdata_o,
   output logic                           i_ack_o,
   // Data bus
   input  logic                           d_req_i,
   input  logic [ADDR_W:0]                d_addr_i,   // Top bit selects control space
   input  logic [mem_bus_pkg::DATA_W-1:0] d_wdata_i,
   input  logic [mem_bus_pkg::STRB_W-1:0] d_wstrb_i,
   output logic [mem_bus_pkg::DATA_W-1:0] d_rdata_o,
   output logic                           d_ack_o,
   // External memory
   output logic                           mem_req_o,
   output logic [ADDR_W-1:0]              mem_addr_o,
   output logic [mem_bus_pkg::DATA_W-1:0] mem_wdata_o,
   output logic [mem_bus_pkg::STRB_W-1:0] mem_wstrb_o,
   input  logic [mem_bus_pkg::DATA_W-1:0] mem_rdata_i,
   input  logic                           mem_ack_i
);

   // First-level back ends, one entry per merge port
   wire [1:0]                          m_req;
   wire [1:0][ADDR_W-1:0]              m_addr;
   wire [1:0][mem_bus_pkg::DATA_W-1:0] m_wdata;
   wire [1:0][mem_bus_pkg::STRB_W-1:0] m_wstrb;
   wire [1:0]                          m_ack;
   logic [mem_bus_pkg::DATA_W-1:0]     m_rdata;

   logic                           l2_req;
   logic [ADDR_W-1:0]              l2_addr;
   logic [mem_bus_pkg::DATA_W-1:0] l2_wdata;
   logic [mem_bus_pkg::STRB_W-1:0] l2_wstrb;
   logic [mem_bus_pkg::DATA_W-1:0] l2_rdata;
   logic                           l2_ack;
   logic                           l2_wtb_empty;
   logic                           dc_invalidate;
   logic                           inv_pending_q;

   // Hold the invalidate until the L2 bus is idle
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         inv_pending_q <= 1'b0;
      end else if (dc_invalidate) begin
         inv_pending_q <= 1'b1;
      end else if (!l2_req) begin
         inv_pending_q <= 1'b0;
      end
   end

   l1_cache #(.ADDR_W(ADDR_W), .L1_LINES_W(L1_LINES_W), .USE_CTRL(1'b0)) icache (
      .clk_i(clk_i), .rst_i(rst_i),
      .req_i(i_req_i), .addr_i({1'b0, i_addr_i}), .wdata_i('0), .wstrb_i('0),
      .rdata_o(i_rdata_o), .ack_o(i_ack_o),
      .be_req_o(m_req[mem_bus_pkg::MASTER_I]), .be_addr_o(m_addr[mem_bus_pkg::MASTER_I]),
      .be_wdata_o(m_wdata[mem_bus_pkg::MASTER_I]), .be_wstrb_o(m_wstrb[mem_bus_pkg::MASTER_I]),
      .be_rdata_i(m_rdata), .be_ack_i(m_ack[mem_bus_pkg::MASTER_I]),
      .invalidate_o(), .wtb_empty_i(1'b1)
   );

   l1_cache #(.ADDR_W(ADDR_W), .L1_LINES_W(L1_LINES_W), .USE_CTRL(1'b1)) dcache (
      .clk_i(clk_i), .rst_i(rst_i),
      .req_i(d_req_i), .addr_i(d_addr_i), .wdata_i(d_wdata_i), .wstrb_i(d_wstrb_i),
      .rdata_o(d_rdata_o), .ack_o(d_ack_o),
      .be_req_o(m_req[mem_bus_pkg::MASTER_D]), .be_addr_o(m_addr[mem_bus_pkg::MASTER_D]),
      .be_wdata_o(m_wdata[mem_bus_pkg::MASTER_D]), .be_wstrb_o(m_wstrb[mem_bus_pkg::MASTER_D]),
      .be_rdata_i(m_rdata), .be_ack_i(m_ack[mem_bus_pkg::MASTER_D]),
      .invalidate_o(dc_invalidate), .wtb_empty_i(l2_wtb_empty)
   );

   bus_merge #(.ADDR_W(ADDR_W)) merge (
      .clk_i(clk_i), .rst_i(rst_i),
      .m_req_i(m_req), .m_addr_i(m_addr), .m_wdata_i(m_wdata), .m_wstrb_i(m_wstrb),
      .m_rdata_o(m_rdata), .m_ack_o(m_ack),
      .s_req_o(l2_req), .s_addr_o(l2_addr), .s_wdata_o(l2_wdata), .s_wstrb_o(l2_wstrb),
      .s_rdata_i(l2_rdata), .s_ack_i(l2_ack)
   );

   l2_cache #(
      .ADDR_W(ADDR_W), .L2_LINES_W(L2_LINES_W), .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
   ) l2cache (
      .clk_i(clk_i), .rst_i(rst_i),
      .req_i(l2_req), .addr_i(l2_addr), .wdata_i(l2_wdata), .wstrb_i(l2_wstrb),
      .rdata_o(l2_rdata), .ack_o(l2_ack),
      .invalidate_i(inv_pending_q && !l2_req), .wtb_empty_o(l2_wtb_empty),
      .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
      .mem_wstrb_o(mem_wstrb_o), .mem_rdata_i(mem_rdata_i), .mem_ack_i(mem_ack_i)
   );

endmodule

`default_nettype wire

/* logic/l1_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
   parameter int ADDR_W     = 16,
   parameter int L1_LINES_W = 4,
   parameter bit USE_CTRL   = 1'b0
) (
   input  logic                           clk_i,
   input  logic                           rst_i,
   // Front end
   input  logic                           req_i,
   input  logic [ADDR_W:0]                addr_i,   // Top bit selects control space
   input  logic [mem_bus_pkg::DATA_W-1:0] wdata_i,
   input  logic [mem_bus_pkg::STRB_W-1:0] wstrb_i,
   output logic [mem_bus_pkg::DATA_W-1:0] rdata_o,
   output logic                           ack_o,
   // Back end
   output logic                           be_req_o,
   output logic [ADDR_W-1:0]              be_addr_o,
   output logic [mem_bus_pkg::DATA_W-1:0] be_wdata_o,
   output logic [mem_bus_pkg::STRB_W-1:0] be_wstrb_o,
   input  logic [mem_bus_pkg::DATA_W-1:0] be_rdata_i,
   input  logic                           be_ack_i,
   // Cache control
   output logic                           invalidate_o,
   input  logic                           wtb_empty_i
);

   localparam int LINES = 2**L1_LINES_W;
   localparam int TAG_W = ADDR_W - L1_LINES_W - 2;

   cache_pkg::l1_state_e state_q;

   logic [TAG_W-1:0]               tag_mem  [LINES];
   logic [mem_bus_pkg::DATA_W-1:0] data_mem [LINES];
   logic [LINES-1:0]               valid_q;

   logic [L1_LINES_W-1:0] idx;
   logic [TAG_W-1:0]      tag;
   logic                  hit;
   logic                  is_write;
   logic                  ctrl_sel;
   mem_bus_pkg::ctrl_op_e ctrl_op;

   assign idx      = addr_i[L1_LINES_W+1:2];
   assign tag      = addr_i[ADDR_W-1:L1_LINES_W+2];
   assign hit      = valid_q[idx] && (tag_mem[idx] == tag);
   assign is_write = |wstrb_i;
   assign ctrl_sel = USE_CTRL && addr_i[ADDR_W];   // Bit ignored without control space
   assign ctrl_op  = mem_bus_pkg::ctrl_op_e'(addr_i[3:2]);

   // One-cycle pulse, CTRL state lasts a single cycle
   assign invalidate_o = (state_q == cache_pkg::L1_CTRL) && is_write
                         && (ctrl_op == mem_bus_pkg::CTRL_INVALIDATE);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= cache_pkg::L1_IDLE;
         valid_q <= '0;
      end else begin
         if (invalidate_o) begin
            valid_q <= '0;
         end
         case (state_q)
            cache_pkg::L1_IDLE: begin
               if (req_i) begin
                  state_q <= ctrl_sel ? cache_pkg::L1_CTRL : cache_pkg::L1_LOOKUP;
               end
            end
            cache_pkg::L1_LOOKUP: begin
               if (!is_write && hit) begin
                  state_q <= cache_pkg::L1_IDLE;
               end else begin
                  state_q <= cache_pkg::L1_BACKEND;
               end
            end
            cache_pkg::L1_BACKEND: begin
               if (be_ack_i) begin
                  state_q <= cache_pkg::L1_IDLE;
                  if (!is_write) begin
                     valid_q[idx] <= 1'b1;   // Line filled
                  end
               end
            end
            default: state_q <= cache_pkg::L1_IDLE;   // CTRL acks in one cycle
         endcase
      end
   end

   // Fill on read miss, byte update on write hit
   always_ff @(posedge clk_i) begin
      if (state_q == cache_pkg::L1_BACKEND && be_ack_i && !is_write) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= be_rdata_i;
      end else if (state_q == cache_pkg::L1_LOOKUP && is_write && hit) begin
         for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
            if (wstrb_i[b]) begin
               data_mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   assign be_req_o   = (state_q == cache_pkg::L1_BACKEND);
   assign be_addr_o  = {addr_i[ADDR_W-1:2], 2'b00};
   assign be_wdata_o = wdata_i;
   assign be_wstrb_o = wstrb_i;   // Zero on a miss fill

   always_comb begin
      ack_o   = 1'b0;
      rdata_o = '0;
      case (state_q)
         cache_pkg::L1_LOOKUP: begin
            ack_o   = !is_write && hit;
            rdata_o = data_mem[idx];
         end
         cache_pkg::L1_BACKEND: begin
            ack_o   = be_ack_i;
            rdata_o = be_rdata_i;
         end
         cache_pkg::L1_CTRL: begin
            ack_o = 1'b1;
            if (!is_write && ctrl_op == mem_bus_pkg::CTRL_WTB_EMPTY) begin
               rdata_o = {{(mem_bus_pkg::DATA_W-1){1'b0}}, wtb_empty_i};
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* logic/l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l2_cache #(
   parameter int ADDR_W        = 16,
   parameter int L2_LINES_W    = 6,
   parameter int WTBUF_DEPTH_W = 2
) (
   input  logic                           clk_i,
   input  logic                           rst_i,
   // Front end from the merge unit
   input  logic                           req_i,
   input  logic [ADDR_W-1:0]              addr_i,
   input  logic [mem_bus_pkg::DATA_W-1:0] wdata_i,
   input  logic [mem_bus_pkg::STRB_W-1:0] wstrb_i,
   output logic [mem_bus_pkg::DATA_W-1:0] rdata_o,
   output logic                           ack_o,
   // Control
   input  logic                           invalidate_i,
   output logic                           wtb_empty_o,
   // External memory
   output logic                           mem_req_o,
   output logic [ADDR_W-1:0]              mem_addr_o,
   output logic [mem_bus_pkg::DATA_W-1:0] mem_wdata_o,
   output logic [mem_bus_pkg::STRB_W-1:0] mem_wstrb_o,
   input  logic [mem_bus_pkg::DATA_W-1:0] mem_rdata_i,
   input  logic                           mem_ack_i
);

   localparam int LINES = 2**L2_LINES_W;
   localparam int TAG_W = ADDR_W - L2_LINES_W - 2;
   localparam int DEPTH = 2**WTBUF_DEPTH_W;

   cache_pkg::l2_state_e state_q;

   logic [TAG_W-1:0]               tag_mem  [LINES];
   logic [mem_bus_pkg::DATA_W-1:0] data_mem [LINES];
   logic [LINES-1:0]               valid_q;

   // Write-through buffer
   logic [ADDR_W-1:0]              wtb_addr [DEPTH];
   logic [mem_bus_pkg::DATA_W-1:0] wtb_data [DEPTH];
   logic [mem_bus_pkg::STRB_W-1:0] wtb_strb [DEPTH];
   logic [WTBUF_DEPTH_W-1:0]       wr_ptr_q;
   logic [WTBUF_DEPTH_W-1:0]       rd_ptr_q;
   logic [WTBUF_DEPTH_W:0]         count_q;

   logic [L2_LINES_W-1:0] idx;
   logic [TAG_W-1:0]      tag;
   logic [ADDR_W-1:0]     word_addr;
   logic                  hit;
   logic                  is_write;
   logic                  wtb_full;
   logic                  push;
   logic                  pop;
   logic                  fetch;

   assign idx       = addr_i[L2_LINES_W+1:2];
   assign tag       = addr_i[ADDR_W-1:L2_LINES_W+2];
   assign word_addr = {addr_i[ADDR_W-1:2], 2'b00};
   assign hit       = valid_q[idx] && (tag_mem[idx] == tag);
   assign is_write  = |wstrb_i;
   assign wtb_full  = (count_q == DEPTH);
   assign wtb_empty_o = (count_q == '0);
   assign fetch     = (state_q == cache_pkg::L2_FETCH);
   assign push      = (state_q == cache_pkg::L2_LOOKUP) && is_write && !wtb_full;
   assign pop       = !wtb_empty_o && mem_ack_i;   // Entry leaves only once memory took it

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q  <= cache_pkg::L2_IDLE;
         valid_q  <= '0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (invalidate_i) begin
            valid_q <= '0;
         end
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q <= count_q + {{WTBUF_DEPTH_W{1'b0}}, push} - {{WTBUF_DEPTH_W{1'b0}}, pop};
         case (state_q)
            cache_pkg::L2_IDLE: begin
               if (req_i) begin
                  state_q <= cache_pkg::L2_LOOKUP;
               end
            end
            cache_pkg::L2_LOOKUP: begin
               if (is_write) begin
                  if (!wtb_full) begin
                     state_q <= cache_pkg::L2_WRITE_PUSH;
                  end
               end else if (hit) begin
                  state_q <= cache_pkg::L2_IDLE;
               end else begin
                  state_q <= cache_pkg::L2_DRAIN_WAIT;
               end
            end
            cache_pkg::L2_DRAIN_WAIT: begin
               if (wtb_empty_o) begin
                  state_q <= cache_pkg::L2_FETCH;
               end
            end
            cache_pkg::L2_FETCH: begin
               if (mem_ack_i) begin
                  state_q      <= cache_pkg::L2_IDLE;
                  valid_q[idx] <= 1'b1;
               end
            end
            default: state_q <= cache_pkg::L2_IDLE;   // WRITE_PUSH acks the stored write
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         wtb_addr[wr_ptr_q] <= word_addr;
         wtb_data[wr_ptr_q] <= wdata_i;
         wtb_strb[wr_ptr_q] <= wstrb_i;
      end
      if (fetch && mem_ack_i) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= mem_rdata_i;
      end else if (push && hit) begin
         for (int b = 0; b < mem_bus_pkg::STRB_W; b++) begin
            if (wstrb_i[b]) begin
               data_mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   // Fetch only runs with the buffer empty, so the port is never shared
   assign mem_req_o   = fetch || !wtb_empty_o;
   assign mem_addr_o  = fetch ? word_addr : wtb_addr[rd_ptr_q];
   assign mem_wdata_o = wtb_data[rd_ptr_q];
   assign mem_wstrb_o = fetch ? '0 : wtb_strb[rd_ptr_q];

   always_comb begin
      ack_o   = 1'b0;
      rdata_o = '0;
      case (state_q)
         cache_pkg::L2_LOOKUP: begin
            ack_o   = !is_write && hit;
            rdata_o = data_mem[idx];
         end
         cache_pkg::L2_FETCH: begin
            ack_o   = mem_ack_i;
            rdata_o = mem_rdata_i;
         end
         cache_pkg::L2_WRITE_PUSH: ack_o = 1'b1;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* logic/mem_bus_pkg.sv */
`default_nettype none

// Native bus definitions shared by all caches and the merge unit
package mem_bus_pkg;

   localparam int DATA_W = 32;           // Bus word
   localparam int STRB_W = DATA_W / 8;   // One bit per byte, all zero means read

   // Merge port indices
   localparam logic MASTER_I = 1'b1;     // Instruction cache, wins arbitration
   localparam logic MASTER_D = 1'b0;     // Data cache

   // Control space opcodes, selected by the word offset
   typedef enum logic [1:0] {
      CTRL_INVALIDATE = 2'd0,   // Write only
      CTRL_WTB_EMPTY  = 2'd1    // Read returns 1 once every write reached memory
   } ctrl_op_e;

endpackage

`default_nettype wire

/* tb/ext_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ext_mem_tb;

   localparam int          ADDR_W        = 16;
   localparam logic [31:0] SEED          = 32'h2478da2d;
   localparam logic [16:0] CTRL_INV_ADDR = 17'h10000;   // Control space word 0
   localparam logic [16:0] CTRL_WTB_ADDR = 17'h10004;   // Control space word 1
   // About 70 accesses, each up to 60 cycles when a miss waits behind a full write buffer
   localparam int MAX_ACCESSES = 70;
   localparam int MISS_CYCLES  = 60;
   localparam int TIMEOUT      = 2 * MAX_ACCESSES * MISS_CYCLES;

   logic        clk;
   logic        rst;
   logic        i_req;
   logic [15:0] i_addr;
   logic [31:0] i_rdata;
   logic        i_ack;
   logic        d_req;
   logic [16:0] d_addr;
   logic [31:0] d_wdata;
   logic [3:0]  d_wstrb;
   logic [31:0] d_rdata;
   logic        d_ack;
   logic        mem_req;
   logic [15:0] mem_addr;
   logic [31:0] mem_wdata;
   logic [3:0]  mem_wstrb;
   logic [31:0] mem_rdata;
   logic        mem_ack;
   logic [2:0]  mem_lat;
   logic [31:0] mem_reads;
   logic [31:0] rand_state;
   logic [31:0] lat_state;
   int          cycles;
   int          n_tests;
   int          n_checks;
   int          n_errors;

   ext_mem #(.ADDR_W(ADDR_W)) DUT (
      .clk_i(clk), .rst_i(rst),
      .i_req_i(i_req), .i_addr_i(i_addr), .i_rdata_o(i_rdata), .i_ack_o(i_ack),
      .d_req_i(d_req), .d_addr_i(d_addr), .d_wdata_i(d_wdata), .d_wstrb_i(d_wstrb),
      .d_rdata_o(d_rdata), .d_ack_o(d_ack),
      .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
      .mem_wstrb_o(mem_wstrb), .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack)
   );

   mem_model #(.ADDR_W(ADDR_W)) memory (
      .clk_i(clk), .rst_i(rst),
      .req_i(mem_req), .addr_i(mem_addr), .wdata_i(mem_wdata), .wstrb_i(mem_wstrb),
      .rdata_o(mem_rdata), .ack_o(mem_ack),
      .latency_i(mem_lat), .read_count_o(mem_reads)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_rand();
      rand_state = lcg_next(rand_state);
      return rand_state;
   endfunction

   // Expected word after a partial write
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] strb);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   always #20 clk = ~clk;

   always @(posedge clk) begin
      lat_state <= lcg_next(lat_state);
      mem_lat   <= 3'd1 + {1'b0, lat_state[17:16]};   // Memory latency 1 to 4
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout: tests did not finish within %0d cycles", TIMEOUT);
         $display("Something failed");
         $finish;
      end
   end

   task automatic compare(input string test, input logic [31:0] expected,
                          input logic [31:0] actual);
      n_checks++;
      if (actual !== expected) begin
         n_errors++;
         $display("ERROR %s expected %h actual %h", test, expected, actual);
      end
   endtask

   task automatic d_access(input logic [16:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, output logic [31:0] rdata);
      @(posedge clk);
      d_req   <= 1'b1;
      d_addr  <= addr;
      d_wdata <= wdata;
      d_wstrb <= wstrb;
      do begin
         @(negedge clk);   // Ack and rdata are stable mid-cycle
      end while (!d_ack);
      rdata = d_rdata;
      @(posedge clk);
      d_req   <= 1'b0;
      d_wstrb <= 4'h0;
   endtask

   task automatic i_read(input logic [15:0] addr, output logic [31:0] rdata);
      @(posedge clk);
      i_req  <= 1'b1;
      i_addr <= addr;
      do begin
         @(negedge clk);
      end while (!i_ack);
      rdata = i_rdata;
      @(posedge clk);
      i_req <= 1'b0;
   endtask

   task automatic wait_drained();
      logic [31:0] status;
      status = '0;
      while (status[0] !== 1'b1) begin
         d_access(CTRL_WTB_ADDR, '0, 4'h0, status);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      n_tests++;
      $display("Test %s finished with %0d errors", name, n_errors - errors_before);
   endtask

   task automatic test_write_read();
      logic [15:0] addrs [8];
      logic [31:0] words [8];
      logic [31:0] r;
      logic [31:0] rdata;
      int          errs;
      errs = n_errors;
      for (int k = 0; k < 8; k++) begin
         r        = next_rand();
         addrs[k] = {1'b0, r[12:3], 3'(k), 2'b00};   // Distinct words in the lower half
         words[k] = next_rand();
         d_access({1'b0, addrs[k]}, words[k], 4'hF, rdata);
      end
      wait_drained();
      for (int k = 0; k < 8; k++) begin
         d_access({1'b0, addrs[k]}, '0, 4'h0, rdata);
         compare("write_read", words[k], rdata);
         memory.backdoor_read(addrs[k], rdata);
         compare("write_read backdoor", words[k], rdata);
      end
      report_test("write_read", errs);
   endtask

   task automatic test_byte_strobes();
      logic [31:0] full_w;
      logic [31:0] part_w;
      logic [3:0]  strb;
      logic [31:0] rdata;
      int          errs;
      errs   = n_errors;
      full_w = 32'h11223344;
      part_w = 32'haabbccdd;
      strb   = 4'b0101;
      d_access(17'h08010, '0, 4'h0, rdata);   // Cache the line so both writes hit
      d_access(17'h08010, full_w, 4'hF, rdata);
      d_access(17'h08010, part_w, strb, rdata);
      d_access(17'h08010, '0, 4'h0, rdata);
      compare("byte_strobes", merge_bytes(full_w, part_w, strb), rdata);
      wait_drained();
      memory.backdoor_read(16'h8010, rdata);
      compare("byte_strobes memory", merge_bytes(full_w, part_w, strb), rdata);
      report_test("byte_strobes", errs);
   endtask

   task automatic test_instr_hits();
      logic [31:0] rdata;
      logic [31:0] reads_before;
      int          errs;
      errs = n_errors;
      for (int k = 0; k < 4; k++) begin
         memory.backdoor_write(16'h8100 + 16'(4*k), 32'hc0de0000 | 32'(k));
      end
      for (int k = 0; k < 4; k++) begin
         i_read(16'h8100 + 16'(4*k), rdata);
         compare("instr_hits", 32'hc0de0000 | 32'(k), rdata);
      end
      // Evict the L2 copies so that only the icache can serve the repeats
      for (int k = 0; k < 4; k++) begin
         d_access({1'b0, 16'h9100 + 16'(4*k)}, '0, 4'h0, rdata);
      end
      @(negedge clk);
      reads_before = mem_reads;
      for (int k = 0; k < 4; k++) begin
         i_read(16'h8100 + 16'(4*k), rdata);
         compare("instr_hits repeat", 32'hc0de0000 | 32'(k), rdata);
      end
      @(negedge clk);
      compare("instr_hits read count", reads_before, mem_reads);   // No memory reads on hits
      report_test("instr_hits", errs);
   endtask

   task automatic test_invalidate();
      logic [31:0] rdata;
      int          errs;
      errs = n_errors;
      memory.backdoor_write(16'h8200, 32'h5555aaaa);
      d_access(17'h08200, '0, 4'h0, rdata);
      compare("invalidate first read", 32'h5555aaaa, rdata);
      memory.backdoor_write(16'h8200, 32'h12345678);
      d_access(17'h08200, '0, 4'h0, rdata);
      compare("invalidate cached", 32'h5555aaaa, rdata);
      d_access(CTRL_INV_ADDR, '0, 4'hF, rdata);
      d_access(17'h08200, '0, 4'h0, rdata);
      compare("invalidate refetch", 32'h12345678, rdata);
      report_test("invalidate", errs);
   endtask

   task automatic test_concurrent();
      logic [31:0] i_data;
      logic [31:0] d_data;
      int          errs;
      errs = n_errors;
      memory.backdoor_write(16'h8300, 32'h1badb002);
      memory.backdoor_write(16'h8304, 32'hd00dfeed);
      fork
         i_read(16'h8300, i_data);
         d_access(17'h08304, '0, 4'h0, d_data);
      join
      compare("concurrent instr", 32'h1badb002, i_data);
      compare("concurrent data", 32'hd00dfeed, d_data);
      report_test("concurrent", errs);
   endtask

   task automatic test_wtb_status();
      logic [31:0] words [6];
      logic [31:0] rdata;
      int          errs;
      errs = n_errors;
      for (int k = 0; k < 6; k++) begin
         words[k] = next_rand();
         d_access({1'b0, 16'h8400 + 16'(4*k)}, words[k], 4'hF, rdata);
      end
      wait_drained();
      for (int k = 0; k < 6; k++) begin
         memory.backdoor_read(16'h8400 + 16'(4*k), rdata);
         compare("wtb_status", words[k], rdata);
      end
      report_test("wtb_status", errs);
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      i_req      = 1'b0;
      i_addr     = '0;
      d_req      = 1'b0;
      d_addr     = '0;
      d_wdata    = '0;
      d_wstrb    = '0;
      mem_lat    = 3'd1;
      rand_state = SEED;
      lat_state  = SEED;
      cycles     = 0;
      n_tests    = 0;
      n_checks   = 0;
      n_errors   = 0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      test_write_read();
      test_byte_strobes();
      test_instr_hits();
      test_invalidate();
      test_concurrent();
      test_wtb_status();
      $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
   parameter int ADDR_W = 16
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              req_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [31:0]       wdata_i,
   input  logic [3:0]        wstrb_i,
   output logic [31:0]       rdata_o,
   output logic              ack_o,
   input  logic [2:0]        latency_i,   // 1 to 4, new value every cycle
   output logic [31:0]       read_count_o
);

   localparam int WORDS = 2**(ADDR_W-2);

   logic [31:0] mem [WORDS];
   logic [2:0]  wait_q;
   logic        busy_q;

   // Fill pattern built from the whole word address
   initial begin
      for (int w = 0; w < WORDS; w++) begin
         mem[w] = {~16'(w), 16'(w)};
      end
   end

   always @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ack_o        <= 1'b0;
         busy_q       <= 1'b0;
         wait_q       <= '0;
         rdata_o      <= '0;
         read_count_o <= '0;
      end else if (ack_o) begin
         ack_o  <= 1'b0;   // req may stay high for the next access
         busy_q <= 1'b0;
      end else if (req_i && !busy_q) begin
         busy_q <= 1'b1;
         wait_q <= latency_i - 3'd1;
      end else if (req_i && wait_q != 3'd0) begin
         wait_q <= wait_q - 3'd1;
      end else if (req_i) begin
         ack_o <= 1'b1;
         if (wstrb_i == 4'h0) begin
            rdata_o      <= mem[addr_i[ADDR_W-1:2]];
            read_count_o <= read_count_o + 1;
         end else begin
            for (int b = 0; b < 4; b++) begin
               if (wstrb_i[b]) begin
                  mem[addr_i[ADDR_W-1:2]][8*b +: 8] <= wdata_i[8*b +: 8];
               end
            end
         end
      end
   end

   task automatic backdoor_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
      mem[addr[ADDR_W-1:2]] = data;
   endtask

   task automatic backdoor_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
      data = mem[addr[ADDR_W-1:2]];
   endtask

endmodule

`default_nettype wire
